// ==== hdl/rotator_cfg_pkg.sv ====
// ==========================================================
// field widths of the weight frame header
// size limits derived from those widths
// vector typedefs for the header fields and kernel counter
// ==========================================================
`default_nettype none

package rotator_cfg_pkg;

  // header field widths
  localparam int KH2_W    = 2;
  localparam int KW2_W    = 2;
  localparam int CIN_W    = 4;
  localparam int COLS_W   = 4;
  localparam int BLOCKS_W = 3;

  // header bits sit at the bottom of the first beat
  localparam int HDR_W = KW2_W + KH2_W + CIN_W + COLS_W + BLOCKS_W;

  // largest odd kernel height and channel count the header can encode
  localparam int KH_MAX  = 2 * (2 ** KH2_W) - 1;
  localparam int CIN_MAX = 2 ** CIN_W;

  typedef logic [KH2_W-1:0]    kh2_t;
  typedef logic [KW2_W-1:0]    kw2_t;
  typedef logic [CIN_W-1:0]    cin_t;
  typedef logic [COLS_W-1:0]   cols_t;
  typedef logic [BLOCKS_W-1:0] blocks_t;

  // kernel row counter, runs 2*kh2 down to 0
  typedef logic [KH2_W:0] kh_cnt_t;

endpackage

`default_nettype wire

// ==== hdl/rotator_fsm_pkg.sv ====
// ==========================================================
// state encodings of the write and read FSMs
// ==========================================================
`default_nettype none

package rotator_fsm_pkg;

  // input side, header then weights into the free bank
  typedef enum logic [1:0] {
    W_IDLE,
    W_GET_HDR,
    W_WRITE,
    W_SWITCH
  } wr_state_e;

  // output side, replays a full bank
  typedef enum logic [1:0] {
    R_IDLE,
    R_READ,
    R_SWITCH
  } rd_state_e;

endpackage

`default_nettype wire

// ==== hdl/weights_header_decode.sv ====
// ==========================================================
// input side of the weight rotator
// write FSM, header field slicing, write address sequencing
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module weights_header_decode
  import rotator_cfg_pkg::*;
  import rotator_fsm_pkg::*;
#(
  parameter int WEIGHT_W   = 64,
  parameter int BANK_DEPTH = KH_MAX * CIN_MAX
) (
  input  wire logic                          aclk,
  input  wire logic                          i_arst_n,
  input  wire logic                          i_s_valid,
  input  wire logic                          i_s_last,
  input  wire logic [WEIGHT_W-1:0]           i_s_data,
  input  wire logic                          i_wr_bank_free,
  output logic                               o_s_ready,
  output logic                               o_wr_bank,
  output logic                               o_hdr_en,
  output kw2_t                               o_hdr_kw2,
  output kh2_t                               o_hdr_kh2,
  output cin_t                               o_hdr_cin_1,
  output cols_t                              o_hdr_cols_1,
  output blocks_t                            o_hdr_blocks_1,
  output logic                               o_wr_en,
  output logic [$clog2(BANK_DEPTH)-1:0]      o_wr_addr,
  output logic [WEIGHT_W-1:0]                o_wr_data,
  output logic                               o_wr_done
);

  localparam int ADDR_W = $clog2(BANK_DEPTH);

  wr_state_e state, state_next;
  logic s_hs;

  // expected address of the beat carrying last
  kh_cnt_t hdr_kh;
  logic [CIN_W:0] hdr_cin;
  logic [ADDR_W-1:0] addr_last;

  // header fields, kw2 in the lowest bits
  assign {o_hdr_blocks_1, o_hdr_cols_1, o_hdr_cin_1, o_hdr_kh2, o_hdr_kw2} =
    i_s_data[HDR_W-1:0];

  assign hdr_kh  = {o_hdr_kh2, 1'b1};
  assign hdr_cin = {1'b0, o_hdr_cin_1} + 1'b1;

  assign o_s_ready = (state == W_GET_HDR) || (state == W_WRITE);
  assign s_hs      = i_s_valid && o_s_ready;
  assign o_hdr_en  = s_hs && (state == W_GET_HDR);
  assign o_wr_en   = s_hs && (state == W_WRITE);
  assign o_wr_done = (state == W_SWITCH);
  assign o_wr_data = i_s_data;

  always_comb begin
    state_next = state;
    unique case (state)
      W_IDLE:    if (i_wr_bank_free) state_next = W_GET_HDR;
      W_GET_HDR: if (s_hs) state_next = W_WRITE;
      W_WRITE:   if (s_hs && i_s_last) state_next = W_SWITCH;
      W_SWITCH:  state_next = W_IDLE;
      default:   state_next = W_IDLE;
    endcase
  end

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state     <= W_IDLE;
      o_wr_bank <= 1'b0;
      o_wr_addr <= '0;
    end else begin
      state <= state_next;
      // hand the filled bank over and move to the other one
      if (state == W_SWITCH) o_wr_bank <= ~o_wr_bank;
      if (o_hdr_en) o_wr_addr <= '0;
      else if (o_wr_en) o_wr_addr <= o_wr_addr + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (o_hdr_en) addr_last <= ADDR_W'(hdr_kh) * ADDR_W'(hdr_cin) - 1'b1;
  end

  // the source marks exactly kh*cin weight beats
  a_last_on_count : assert property (@(posedge aclk) disable iff (!i_arst_n)
    o_wr_en |-> (i_s_last == (o_wr_addr == addr_last)));

endmodule

`default_nettype wire

// ==== hdl/weights_bank_pair.sv ====
// ==========================================================
// two ping-pong weight banks with async read
// per-bank header registers and full flags
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module weights_bank_pair
  import rotator_cfg_pkg::*;
#(
  parameter int WEIGHT_W   = 64,
  parameter int BANK_DEPTH = KH_MAX * CIN_MAX
) (
  input  wire logic                          aclk,
  input  wire logic                          i_arst_n,
  input  wire logic                          i_wr_bank,
  input  wire logic                          i_hdr_en,
  input  wire kw2_t                          i_hdr_kw2,
  input  wire kh2_t                          i_hdr_kh2,
  input  wire cin_t                          i_hdr_cin_1,
  input  wire cols_t                         i_hdr_cols_1,
  input  wire blocks_t                       i_hdr_blocks_1,
  input  wire logic                          i_wr_en,
  input  wire logic [$clog2(BANK_DEPTH)-1:0] i_wr_addr,
  input  wire logic [WEIGHT_W-1:0]           i_wr_data,
  input  wire logic                          i_wr_done,
  input  wire logic                          i_rd_bank,
  input  wire logic [$clog2(BANK_DEPTH)-1:0] i_rd_addr,
  input  wire logic                          i_rd_done,
  output logic                               o_wr_bank_free,
  output logic                               o_rd_bank_full,
  output logic [WEIGHT_W-1:0]                o_rd_data,
  output kw2_t                               o_rd_kw2,
  output kh2_t                               o_rd_kh2,
  output cin_t                               o_rd_cin_1,
  output cols_t                              o_rd_cols_1,
  output blocks_t                            o_rd_blocks_1
);

  logic [WEIGHT_W-1:0] mem [2][BANK_DEPTH];

  kw2_t    hdr_kw2      [2];
  kh2_t    hdr_kh2      [2];
  cin_t    hdr_cin_1    [2];
  cols_t   hdr_cols_1   [2];
  blocks_t hdr_blocks_1 [2];
  logic [1:0] full;

  always_ff @(posedge aclk) begin
    if (i_wr_en) mem[i_wr_bank][i_wr_addr] <= i_wr_data;
  end

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      full <= '0;
      for (int i = 0; i < 2; i++) begin
        hdr_kw2[i]      <= '0;
        hdr_kh2[i]      <= '0;
        hdr_cin_1[i]    <= '0;
        hdr_cols_1[i]   <= '0;
        hdr_blocks_1[i] <= '0;
      end
    end else begin
      if (i_hdr_en) begin
        hdr_kw2[i_wr_bank]      <= i_hdr_kw2;
        hdr_kh2[i_wr_bank]      <= i_hdr_kh2;
        hdr_cin_1[i_wr_bank]    <= i_hdr_cin_1;
        hdr_cols_1[i_wr_bank]   <= i_hdr_cols_1;
        hdr_blocks_1[i_wr_bank] <= i_hdr_blocks_1;
      end
      // set by the writer, cleared by the reader
      if (i_wr_done) full[i_wr_bank] <= 1'b1;
      if (i_rd_done) full[i_rd_bank] <= 1'b0;
    end
  end

  assign o_wr_bank_free = !full[i_wr_bank];
  assign o_rd_bank_full = full[i_rd_bank];

  assign o_rd_data     = mem[i_rd_bank][i_rd_addr];
  assign o_rd_kw2      = hdr_kw2[i_rd_bank];
  assign o_rd_kh2      = hdr_kh2[i_rd_bank];
  assign o_rd_cin_1    = hdr_cin_1[i_rd_bank];
  assign o_rd_cols_1   = hdr_cols_1[i_rd_bank];
  assign o_rd_blocks_1 = hdr_blocks_1[i_rd_bank];

  // the writer only touches a bank the reader has released
  a_no_write_full : assert property (@(posedge aclk) disable iff (!i_arst_n)
    (i_wr_en || i_hdr_en) |-> !full[i_wr_bank]);

endmodule

`default_nettype wire

// ==== hdl/weights_read_rotator.sv ====
// ==========================================================
// output side of the weight rotator
// read FSM, nested kh/cin/cols/blocks down-counters
// last marker and side flags
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module weights_read_rotator
  import rotator_cfg_pkg::*;
  import rotator_fsm_pkg::*;
#(
  parameter int WEIGHT_W   = 64,
  parameter int BANK_DEPTH = KH_MAX * CIN_MAX
) (
  input  wire logic                          aclk,
  input  wire logic                          i_arst_n,
  input  wire logic                          i_m_ready,
  input  wire logic                          i_rd_bank_full,
  input  wire logic [WEIGHT_W-1:0]           i_rd_data,
  input  wire kw2_t                          i_rd_kw2,
  input  wire kh2_t                          i_rd_kh2,
  input  wire cin_t                          i_rd_cin_1,
  input  wire cols_t                         i_rd_cols_1,
  input  wire blocks_t                       i_rd_blocks_1,
  output logic                               o_rd_bank,
  output logic [$clog2(BANK_DEPTH)-1:0]      o_rd_addr,
  output logic                               o_rd_done,
  output logic                               o_m_valid,
  output logic [WEIGHT_W-1:0]                o_m_data,
  output logic                               o_m_last,
  output logic                               o_m_is_cin_last,
  output logic                               o_m_is_cols_1_k2,
  output logic                               o_m_is_top_block,
  output logic                               o_m_is_bottom_block,
  output kw2_t                               o_m_kw2
);

  rd_state_e state, state_next;

  kh_cnt_t kh_cnt;
  cin_t    cin_cnt;
  cols_t   cols_cnt;
  blocks_t blocks_cnt;

  logic m_hs;
  logic kh_zero, cin_zero, cols_zero, blocks_zero;
  logic pass_end;

  assign kh_zero     = (kh_cnt == '0);
  assign cin_zero    = (cin_cnt == '0);
  assign cols_zero   = (cols_cnt == '0);
  assign blocks_zero = (blocks_cnt == '0);
  assign pass_end    = kh_zero && cin_zero;

  assign o_m_valid = (state == R_READ);
  assign o_rd_done = (state == R_SWITCH);
  assign m_hs      = o_m_valid && i_m_ready;

  always_comb begin
    state_next = state;
    unique case (state)
      R_IDLE:   if (i_rd_bank_full) state_next = R_READ;
      R_READ:   if (m_hs && o_m_last) state_next = R_SWITCH;
      R_SWITCH: state_next = R_IDLE;
      default:  state_next = R_IDLE;
    endcase
  end

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state      <= R_IDLE;
      o_rd_bank  <= 1'b0;
      o_rd_addr  <= '0;
      kh_cnt     <= '0;
      cin_cnt    <= '0;
      cols_cnt   <= '0;
      blocks_cnt <= '0;
    end else begin
      state <= state_next;
      if (state == R_SWITCH) o_rd_bank <= ~o_rd_bank;
      if (state == R_IDLE) begin
        // preload from the stored header while waiting
        o_rd_addr  <= '0;
        kh_cnt     <= {i_rd_kh2, 1'b0};
        cin_cnt    <= i_rd_cin_1;
        cols_cnt   <= i_rd_cols_1;
        blocks_cnt <= i_rd_blocks_1;
      end else if (m_hs) begin
        o_rd_addr <= pass_end ? '0 : o_rd_addr + 1'b1;
        kh_cnt    <= kh_zero ? {i_rd_kh2, 1'b0} : kh_cnt - 1'b1;
        if (kh_zero) cin_cnt <= cin_zero ? i_rd_cin_1 : cin_cnt - 1'b1;
        if (pass_end) cols_cnt <= cols_zero ? i_rd_cols_1 : cols_cnt - 1'b1;
        if (pass_end && cols_zero) begin
          blocks_cnt <= blocks_zero ? i_rd_blocks_1 : blocks_cnt - 1'b1;
        end
      end
    end
  end

  assign o_m_data = i_rd_data;
  assign o_m_kw2  = i_rd_kw2;
  assign o_m_last = pass_end && cols_zero && blocks_zero;

  assign o_m_is_cin_last     = pass_end;
  // cols counter holds cols_1 minus the column index
  assign o_m_is_cols_1_k2    = (cols_cnt == cols_t'(i_rd_kw2));
  assign o_m_is_top_block    = (blocks_cnt == i_rd_blocks_1);
  assign o_m_is_bottom_block = blocks_zero;

  // a stalled beat must not move, bank contents included
  a_hold_stall : assert property (@(posedge aclk) disable iff (!i_arst_n)
    (o_m_valid && !i_m_ready) |=> (o_m_valid && $stable(o_m_data) && $stable(o_m_last) &&
      $stable(o_m_is_cin_last) && $stable(o_m_is_cols_1_k2) && $stable(o_m_is_top_block) &&
      $stable(o_m_is_bottom_block) && $stable(o_m_kw2)));

endmodule

`default_nettype wire

// ==== hdl/axis_weight_rotator.sv ====
// ==========================================================
// weight rotator top level
// header decode, ping-pong bank pair, read rotator
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module axis_weight_rotator
  import rotator_cfg_pkg::*;
#(
  parameter int WEIGHT_W   = 64,
  parameter int BANK_DEPTH = KH_MAX * CIN_MAX
) (
  input  wire logic                aclk,
  input  wire logic                i_arst_n,
  input  wire logic                i_s_valid,
  output logic                     o_s_ready,
  input  wire logic [WEIGHT_W-1:0] i_s_data,
  input  wire logic                i_s_last,
  output logic                     o_m_valid,
  input  wire logic                i_m_ready,
  output logic [WEIGHT_W-1:0]      o_m_data,
  output logic                     o_m_last,
  output logic                     o_m_is_cin_last,
  output logic                     o_m_is_cols_1_k2,
  output logic                     o_m_is_top_block,
  output logic                     o_m_is_bottom_block,
  output kw2_t                     o_m_kw2
);

  localparam int ADDR_W = $clog2(BANK_DEPTH);

  // write side
  logic wr_bank, hdr_en, wr_en, wr_done, wr_bank_free;
  kw2_t hdr_kw2;
  kh2_t hdr_kh2;
  cin_t hdr_cin_1;
  cols_t hdr_cols_1;
  blocks_t hdr_blocks_1;
  logic [ADDR_W-1:0] wr_addr;
  logic [WEIGHT_W-1:0] wr_data;

  // read side
  logic rd_bank, rd_done, rd_bank_full;
  logic [ADDR_W-1:0] rd_addr;
  logic [WEIGHT_W-1:0] rd_data;
  kw2_t rd_kw2;
  kh2_t rd_kh2;
  cin_t rd_cin_1;
  cols_t rd_cols_1;
  blocks_t rd_blocks_1;

  weights_header_decode #(
    .WEIGHT_W   (WEIGHT_W),
    .BANK_DEPTH (BANK_DEPTH)
  ) weights_header_decode_i (
    .aclk           (aclk),
    .i_arst_n       (i_arst_n),
    .i_s_valid      (i_s_valid),
    .i_s_last       (i_s_last),
    .i_s_data       (i_s_data),
    .i_wr_bank_free (wr_bank_free),
    .o_s_ready      (o_s_ready),
    .o_wr_bank      (wr_bank),
    .o_hdr_en       (hdr_en),
    .o_hdr_kw2      (hdr_kw2),
    .o_hdr_kh2      (hdr_kh2),
    .o_hdr_cin_1    (hdr_cin_1),
    .o_hdr_cols_1   (hdr_cols_1),
    .o_hdr_blocks_1 (hdr_blocks_1),
    .o_wr_en        (wr_en),
    .o_wr_addr      (wr_addr),
    .o_wr_data      (wr_data),
    .o_wr_done      (wr_done)
  );

  weights_bank_pair #(
    .WEIGHT_W   (WEIGHT_W),
    .BANK_DEPTH (BANK_DEPTH)
  ) weights_bank_pair_i (
    .aclk           (aclk),
    .i_arst_n       (i_arst_n),
    .i_wr_bank      (wr_bank),
    .i_hdr_en       (hdr_en),
    .i_hdr_kw2      (hdr_kw2),
    .i_hdr_kh2      (hdr_kh2),
    .i_hdr_cin_1    (hdr_cin_1),
    .i_hdr_cols_1   (hdr_cols_1),
    .i_hdr_blocks_1 (hdr_blocks_1),
    .i_wr_en        (wr_en),
    .i_wr_addr      (wr_addr),
    .i_wr_data      (wr_data),
    .i_wr_done      (wr_done),
    .i_rd_bank      (rd_bank),
    .i_rd_addr      (rd_addr),
    .i_rd_done      (rd_done),
    .o_wr_bank_free (wr_bank_free),
    .o_rd_bank_full (rd_bank_full),
    .o_rd_data      (rd_data),
    .o_rd_kw2       (rd_kw2),
    .o_rd_kh2       (rd_kh2),
    .o_rd_cin_1     (rd_cin_1),
    .o_rd_cols_1    (rd_cols_1),
    .o_rd_blocks_1  (rd_blocks_1)
  );

  weights_read_rotator #(
    .WEIGHT_W   (WEIGHT_W),
    .BANK_DEPTH (BANK_DEPTH)
  ) weights_read_rotator_i (
    .aclk                (aclk),
    .i_arst_n            (i_arst_n),
    .i_m_ready           (i_m_ready),
    .i_rd_bank_full      (rd_bank_full),
    .i_rd_data           (rd_data),
    .i_rd_kw2            (rd_kw2),
    .i_rd_kh2            (rd_kh2),
    .i_rd_cin_1          (rd_cin_1),
    .i_rd_cols_1         (rd_cols_1),
    .i_rd_blocks_1       (rd_blocks_1),
    .o_rd_bank           (rd_bank),
    .o_rd_addr           (rd_addr),
    .o_rd_done           (rd_done),
    .o_m_valid           (o_m_valid),
    .o_m_data            (o_m_data),
    .o_m_last            (o_m_last),
    .o_m_is_cin_last     (o_m_is_cin_last),
    .o_m_is_cols_1_k2    (o_m_is_cols_1_k2),
    .o_m_is_top_block    (o_m_is_top_block),
    .o_m_is_bottom_block (o_m_is_bottom_block),
    .o_m_kw2             (o_m_kw2)
  );

endmodule

`default_nettype wire

// ==== tb/tb_axis_weight_rotator.sv ====
// ==========================================================
// testbench for the weight rotator
// queue model of expected output beats, concurrent checks,
// clock, reset, random back-pressure and cycle timeout
// ==========================================================
`timescale 1ns/100ps
`default_nettype none

module tb_axis_weight_rotator
  import rotator_cfg_pkg::*;
;

  localparam int WEIGHT_W   = 64;
  localparam int BANK_DEPTH = 112;
  localparam int EXP_W      = WEIGHT_W + 5 + KW2_W;
  // replay, flags, back-pressure, three ping-pong frames, minimum frame
  localparam int TOTAL_BEATS = 36 + 45 + 120 + 6 + 8 + 112 + 1;
  localparam int CYCLE_LIMIT = 20 * TOTAL_BEATS + 200;

  logic                aclk;
  logic                i_arst_n;
  logic                i_s_valid;
  logic                o_s_ready;
  logic [WEIGHT_W-1:0] i_s_data;
  logic                i_s_last;
  logic                o_m_valid;
  logic                i_m_ready;
  logic [WEIGHT_W-1:0] o_m_data;
  logic                o_m_last;
  logic                o_m_is_cin_last;
  logic                o_m_is_cols_1_k2;
  logic                o_m_is_top_block;
  logic                o_m_is_bottom_block;
  kw2_t                o_m_kw2;

  logic [EXP_W-1:0]    exp_q [$];
  logic [WEIGHT_W-1:0] wts [$];
  logic [EXP_W-1:0]    exp_beat = '0;
  logic                exp_avail = 1'b0;
  logic [EXP_W-1:0]    act_beat;
  int                  chk_idx = 0;
  int                  hdr_count = 0;
  int                  cycle_cnt = 0;
  int                  seed = 32'hf9de;
  int                  ready_mode = 0;
  int                  hdr_base;
  string               test_name = "reset";

  axis_weight_rotator #(
    .WEIGHT_W   (WEIGHT_W),
    .BANK_DEPTH (BANK_DEPTH)
  ) axis_weight_rotator_i (
    .aclk                (aclk),
    .i_arst_n            (i_arst_n),
    .i_s_valid           (i_s_valid),
    .o_s_ready           (o_s_ready),
    .i_s_data            (i_s_data),
    .i_s_last            (i_s_last),
    .o_m_valid           (o_m_valid),
    .i_m_ready           (i_m_ready),
    .o_m_data            (o_m_data),
    .o_m_last            (o_m_last),
    .o_m_is_cin_last     (o_m_is_cin_last),
    .o_m_is_cols_1_k2    (o_m_is_cols_1_k2),
    .o_m_is_top_block    (o_m_is_top_block),
    .o_m_is_bottom_block (o_m_is_bottom_block),
    .o_m_kw2             (o_m_kw2)
  );

  assign act_beat = {o_m_data, o_m_last, o_m_is_cin_last, o_m_is_cols_1_k2,
                     o_m_is_top_block, o_m_is_bottom_block, o_m_kw2};

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  // ready_mode selects low, high or random output ready
  initial begin
    i_m_ready = 1'b0;
    forever begin
      @(posedge aclk);
      #1;
      if (ready_mode == 2) i_m_ready = 1'($random(seed));
      else i_m_ready = (ready_mode == 1);
    end
  end

  always @(posedge aclk) begin
    if (i_arst_n && o_m_valid && i_m_ready) chk_idx <= chk_idx + 1;
  end

  // expected beat at the head of the model queue
  always @(negedge aclk) begin
    exp_avail = (chk_idx < exp_q.size());
    if (exp_avail) exp_beat = exp_q[chk_idx];
  end

  always @(posedge aclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      fail_run($sformatf("timeout after %0d cycles in test %s, %0d of %0d beats seen",
                         cycle_cnt, test_name, chk_idx, exp_q.size()));
    end
  end

  a_reset_quiet : assert property (@(posedge aclk)
    !i_arst_n |-> (!o_s_ready && !o_m_valid))
    else fail_run("ready or valid active during reset");

  a_no_extra : assert property (@(posedge aclk) disable iff (!i_arst_n)
    (o_m_valid && i_m_ready) |-> exp_avail)
    else fail_run($sformatf("output beat in test %s with no expected beat left", test_name));

  a_beat_match : assert property (@(posedge aclk) disable iff (!i_arst_n)
    (o_m_valid && i_m_ready && exp_avail) |-> (act_beat == exp_beat))
    else fail_run($sformatf("FAILED %s beat %0d expected %h actual %h", test_name,
                            $sampled(chk_idx), exp_beat, $sampled(act_beat)));

  a_stall_hold : assert property (@(posedge aclk) disable iff (!i_arst_n)
    (o_m_valid && !i_m_ready) |=> (o_m_valid && $stable(act_beat)))
    else fail_run($sformatf("output changed under back-pressure in test %s", test_name));

  // expands one frame into its output beats
  task automatic queue_frame(input int kw2, input int kh2, input int cin_1,
                             input int cols_1, input int blocks_1);
    int p;
    int total;
    int q;
    int c;
    int b;
    logic [EXP_W-1:0] beat;
    p = (2 * kh2 + 1) * (cin_1 + 1);
    total = p * (cols_1 + 1) * (blocks_1 + 1);
    for (int n = 0; n < total; n++) begin
      q = n / p;
      c = q % (cols_1 + 1);
      b = q / (cols_1 + 1);
      beat = {wts[n % p], n == total - 1, (n % p) == p - 1, (cols_1 - c) == kw2,
              b == 0, b == blocks_1, kw2_t'(kw2)};
      exp_q.push_back(beat);
    end
  endtask

  task automatic send_beat(input logic [WEIGHT_W-1:0] data, input logic last);
    logic accepted;
    i_s_valid = 1'b1;
    i_s_data  = data;
    i_s_last  = last;
    accepted  = 1'b0;
    while (!accepted) begin
      @(negedge aclk);
      accepted = o_s_ready;
      @(posedge aclk);
    end
    #1;
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
  endtask

  task automatic send_frame(input int kw2, input int kh2, input int cin_1,
                            input int cols_1, input int blocks_1);
    int p;
    logic [WEIGHT_W-1:0] hdr;
    p = (2 * kh2 + 1) * (cin_1 + 1);
    wts.delete();
    for (int i = 0; i < p; i++) wts.push_back(WEIGHT_W'({$random(seed), $random(seed)}));
    queue_frame(kw2, kh2, cin_1, cols_1, blocks_1);
    hdr = '0;
    hdr[HDR_W-1:0] = {blocks_t'(blocks_1), cols_t'(cols_1), cin_t'(cin_1),
                      kh2_t'(kh2), kw2_t'(kw2)};
    send_beat(hdr, 1'b0);
    hdr_count++;
    for (int i = 0; i < p; i++) send_beat(wts[i], i == p - 1);
  endtask

  task automatic wait_drained();
    while (chk_idx < exp_q.size()) begin
      @(posedge aclk);
      #1;
    end
  endtask

  initial begin
    i_arst_n  = 1'b0;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_s_last  = 1'b0;
    repeat (5) @(posedge aclk);
    #1;
    i_arst_n = 1'b1;

    test_name  = "replay";
    ready_mode = 1;
    send_frame(1, 1, 1, 2, 1);
    wait_drained();

    test_name = "flags";
    send_frame(2, 0, 2, 4, 2);
    wait_drained();

    test_name  = "back_pressure";
    ready_mode = 2;
    send_frame(0, 2, 3, 1, 2);
    wait_drained();

    // output held off until the second header is in
    test_name  = "ping_pong";
    ready_mode = 0;
    hdr_base   = hdr_count;
    fork
      begin
        send_frame(1, 1, 0, 1, 0);
        send_frame(0, 0, 3, 0, 1);
        send_frame(3, 3, 1, 3, 1);
      end
      begin
        while (hdr_count < hdr_base + 2) begin
          @(posedge aclk);
          #1;
        end
        // first frame already waiting at the output
        assert (o_m_valid)
          else fail_run($sformatf("FAILED %s o_m_valid expected 1 actual %0b", test_name,
                                  o_m_valid));
        ready_mode = 2;
      end
    join
    wait_drained();

    test_name  = "min_frame";
    ready_mode = 1;
    send_frame(0, 0, 0, 0, 0);
    wait_drained();

    // room for any stray beat to show up
    repeat (20) @(posedge aclk);
    if (chk_idx == exp_q.size()) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      fail_run($sformatf("beat count differs, saw %0d of %0d", chk_idx, exp_q.size()));
    end
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/rotator_cfg_pkg.sv
hdl/rotator_fsm_pkg.sv
hdl/weights_header_decode.sv
hdl/weights_bank_pair.sv
hdl/weights_read_rotator.sv
hdl/axis_weight_rotator.sv
tb/tb_axis_weight_rotator.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the weight rotator testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axis_weight_rotator -f filelist.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
